// File: hw/rdp_macros.svh
// ********************************************************
// Width, depth and delay constants of the read datapath
// Register field positions of the CONFIG and STATUS words
// ********************************************************

`ifndef RDP_MACROS_SVH
`define RDP_MACROS_SVH

// Data organization of one AFI word at half rate
`define RDP_DQ_GROUP_WIDTH 4
`define RDP_NUM_GROUPS 2
`define RDP_NUM_SLOTS 4
`define RDP_MEM_DQ_WIDTH 8
`define RDP_AFI_DATA_WIDTH 32

// Read latency prediction
`define RDP_MAX_READ_LATENCY 16
`define RDP_LATENCY_WIDTH 4

// Read data buffering
`define RDP_FIFO_DEPTH 8
`define RDP_FIFO_ADDR_WIDTH 3

// On-die termination window, derived from tRL
`define RDP_TRL_WIDTH 4
`define RDP_TRL_MAX 10
`define RDP_OCT_SHIFT_LEN 8
`define RDP_OCT_ON_OFFSET 4
`define RDP_OCT_OFF_OFFSET 6

// Wishbone register block
`define RDP_WB_DATA_WIDTH 32
`define RDP_WB_ADDR_WIDTH 2
`define RDP_CFG_LATENCY_LSB 0
`define RDP_CFG_TRL_LSB 8
`define RDP_STS_UNDERFLOW_BIT 0
`define RDP_STS_OVERFLOW_BIT 1

`endif

// File: hw/rdp_pkg.sv
// ********************************************************
// Shared types of the read datapath
// Read data word union and register word address
// ********************************************************

`default_nettype none

`include "rdp_macros.svh"

package rdp_pkg;

	// ********************************************************
	// Read data word
	// ********************************************************

	// The DDIO delivers one flat word per AFI cycle
	// The same bits are ordered by DQS group first and by time slot within a group
	// Group g, slot t therefore sits at bit g*16+t*4
	typedef union packed
	{
		logic [`RDP_AFI_DATA_WIDTH-1:0] flat;
		logic [`RDP_NUM_GROUPS-1:0][`RDP_NUM_SLOTS-1:0][`RDP_DQ_GROUP_WIDTH-1:0] by_group;
	} rdp_read_word_u;

	// ********************************************************
	// Register map
	// ********************************************************

	// Word addresses of the Wishbone register block
	// Addresses 2 and 3 are not decoded and read back as zero
	typedef enum logic [`RDP_WB_ADDR_WIDTH-1:0]
	{
		CONFIG = 2'd0,
		STATUS = 2'd1
	} rdp_reg_addr_t;

endpackage

`default_nettype wire

// File: hw/rdp_config_regs.sv
// ********************************************************
// Wishbone classic slave with the configuration registers
// CONFIG holds the latency tap and tRL
// STATUS holds sticky FIFO underflow and overflow flags
// ********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_config_regs
(
	input  wire logic                            pll_afi_clk,
	input  wire logic                            reset_n_afi_clk,
	input  wire logic                            wb_cyc_i,
	input  wire logic                            wb_stb_i,
	input  wire logic                            wb_we_i,
	input  wire logic [`RDP_WB_ADDR_WIDTH-1:0]   wb_adr_i,
	input  wire logic [`RDP_WB_DATA_WIDTH-1:0]   wb_dat_i,
	output logic      [`RDP_WB_DATA_WIDTH-1:0]   wb_dat_o,
	output logic                                 wb_ack_o,
	input  wire logic                            underflow_i,
	input  wire logic                            overflow_i,
	output logic      [`RDP_LATENCY_WIDTH-1:0]   latency_o,
	output logic      [`RDP_TRL_WIDTH-1:0]       trl_o
);

	import rdp_pkg::*;

	rdp_reg_addr_t                  reg_addr;
	logic                           wb_access;
	logic                           wr_config;
	logic                           wr_status;
	logic                           underflow_sticky;
	logic                           overflow_sticky;
	logic [`RDP_WB_DATA_WIDTH-1:0]  rd_data;

	// An access is taken on the first cycle that cyc and stb are seen with ack low
	// Ack follows on the next edge and drops again one cycle later
	assign wb_access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign reg_addr = rdp_reg_addr_t'(wb_adr_i);
	assign wr_config = wb_access & wb_we_i & (reg_addr == CONFIG);
	assign wr_status = wb_access & wb_we_i & (reg_addr == STATUS);

	// Read data mux, unused bits and undecoded addresses read as zero
	always_comb
	begin
		rd_data = '0;
		case (reg_addr)
			CONFIG:
			begin
				rd_data[`RDP_CFG_LATENCY_LSB +: `RDP_LATENCY_WIDTH] = latency_o;
				rd_data[`RDP_CFG_TRL_LSB +: `RDP_TRL_WIDTH] = trl_o;
			end
			STATUS:
			begin
				rd_data[`RDP_STS_UNDERFLOW_BIT] = underflow_sticky;
				rd_data[`RDP_STS_OVERFLOW_BIT] = overflow_sticky;
			end
			default:
			begin
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
			latency_o <= '0;
			trl_o <= '0;
			underflow_sticky <= 1'b0;
			overflow_sticky <= 1'b0;
		end
		else
		begin
			wb_ack_o <= wb_access;
			// Read data is captured together with the ack
			if (wb_access && !wb_we_i)
				wb_dat_o <= rd_data;
			if (wr_config)
			begin
				latency_o <= wb_dat_i[`RDP_CFG_LATENCY_LSB +: `RDP_LATENCY_WIDTH];
				trl_o <= wb_dat_i[`RDP_CFG_TRL_LSB +: `RDP_TRL_WIDTH];
			end
			// A new event wins over a write-1-to-clear in the same cycle
			if (underflow_i)
				underflow_sticky <= 1'b1;
			else if (wr_status && wb_dat_i[`RDP_STS_UNDERFLOW_BIT])
				underflow_sticky <= 1'b0;
			if (overflow_i)
				overflow_sticky <= 1'b1;
			else if (wr_status && wb_dat_i[`RDP_STS_OVERFLOW_BIT])
				overflow_sticky <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/rdp_valid_predictor.sv
// ********************************************************
// Read-latency valid prediction
// Two latency shifters with a programmable tap
// Produces the AFI read valid and the read FIFO pop
// ********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_valid_predictor
(
	input  wire logic                           pll_afi_clk,
	input  wire logic                           reset_n_afi_clk,
	input  wire logic                           afi_rdata_en_i,
	input  wire logic                           afi_rdata_en_full_i,
	input  wire logic [`RDP_LATENCY_WIDTH-1:0]  latency_i,
	output logic                                read_valid_o,
	output logic                                fifo_pop_o
);

	// Stage j holds the request sampled j edges before the most recent one
	// A request seen at edge n therefore reaches stage L right after edge n+L
	logic [`RDP_MAX_READ_LATENCY-1:0] latency_shifter;
	logic [`RDP_MAX_READ_LATENCY-1:0] full_latency_shifter;
	logic                             read_valid_tap;

	// Each request cycle is one token, and the controller guarantees the
	// spacing, so the shifter never needs back-pressure
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
			full_latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[`RDP_MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			full_latency_shifter <=
				{full_latency_shifter[`RDP_MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// The tap of the enable shifter feeds the registered valid
	assign read_valid_tap = latency_shifter[latency_i];

	// The full-enable tap pops the FIFO combinationally during the tap cycle,
	// so the popped word lands on the AFI at the same edge as valid
	assign fifo_pop_o = full_latency_shifter[latency_i];

	// Valid is high for the cycle after edge n+L+1
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			read_valid_o <= 1'b0;
		else
			read_valid_o <= read_valid_tap;
	end

endmodule

`default_nettype wire

// File: hw/rdp_read_fifo.sv
// ********************************************************
// Single-clock read data FIFO
// Circular buffer with occupancy count
// Registered outputs in slot-major and group-major order
// Underflow and overflow event pulses
// ********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_read_fifo
(
	input  wire logic                            pll_afi_clk,
	input  wire logic                            reset_n_afi_clk,
	input  wire logic                            push_i,
	input  wire rdp_pkg::rdp_read_word_u         push_data_i,
	input  wire logic                            pop_i,
	output logic      [`RDP_AFI_DATA_WIDTH-1:0]  afi_rdata_o,
	output logic      [`RDP_AFI_DATA_WIDTH-1:0]  phy_mux_read_fifo_q_o,
	output logic                                 underflow_o,
	output logic                                 overflow_o
);

	import rdp_pkg::*;

	rdp_read_word_u                    fifo_mem [`RDP_FIFO_DEPTH];
	logic [`RDP_FIFO_ADDR_WIDTH-1:0]   wr_ptr;
	logic [`RDP_FIFO_ADDR_WIDTH-1:0]   rd_ptr;
	logic [`RDP_FIFO_ADDR_WIDTH:0]     fifo_count;
	logic                              fifo_empty;
	logic                              fifo_full;
	logic                              do_push;
	logic                              do_pop;
	rdp_read_word_u                    head_word;
	logic [`RDP_NUM_SLOTS-1:0][`RDP_NUM_GROUPS-1:0][`RDP_DQ_GROUP_WIDTH-1:0] head_slot_major;

	assign fifo_empty = (fifo_count == 0);
	assign fifo_full = (fifo_count == `RDP_FIFO_DEPTH);
	assign do_push = push_i & ~fifo_full;
	assign do_pop = pop_i & ~fifo_empty;

	// Events are flagged in the cycle of the offending request
	assign overflow_o = push_i & fifo_full;
	assign underflow_o = pop_i & fifo_empty;

	assign head_word = fifo_mem[rd_ptr];

	// Slot t, group g moves to bit t*8+g*4 for the AFI side
	always_comb
	begin
		for (int t = 0; t < `RDP_NUM_SLOTS; t++)
			for (int g = 0; g < `RDP_NUM_GROUPS; g++)
				head_slot_major[t][g] = head_word.by_group[g][t];
	end

	// Storage
	always_ff @(posedge pll_afi_clk)
	begin
		if (do_push)
			fifo_mem[wr_ptr] <= push_data_i;
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
		end
	end

	// Output words change only on a pop, an empty pop presents zeros
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_o <= '0;
			phy_mux_read_fifo_q_o <= '0;
		end
		else if (pop_i)
		begin
			if (fifo_empty)
			begin
				afi_rdata_o <= '0;
				phy_mux_read_fifo_q_o <= '0;
			end
			else
			begin
				afi_rdata_o <= head_slot_major;
				phy_mux_read_fifo_q_o <= head_word.flat;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/rdp_oct_control.sv
// ********************************************************
// On-die termination window control
// Read-enable history and tRL-derived on and off delays
// ********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_oct_control
(
	input  wire logic                       pll_afi_clk,
	input  wire logic                       reset_n_afi_clk,
	input  wire logic                       afi_rdata_en_full_i,
	input  wire logic [`RDP_TRL_WIDTH-1:0]  trl_i,
	output logic                            force_oct_off_o
);

	localparam logic [`RDP_TRL_WIDTH-1:0] TRL_MAX_VAL = `RDP_TRL_MAX;
	localparam logic [`RDP_TRL_WIDTH:0]   ON_OFFSET = `RDP_OCT_ON_OFFSET;
	localparam logic [`RDP_TRL_WIDTH:0]   OFF_OFFSET = `RDP_OCT_OFF_OFFSET;

	logic [`RDP_OCT_SHIFT_LEN-1:0]  rdata_en_hist;
	logic [`RDP_OCT_SHIFT_LEN:0]    rdata_en_shifter;
	logic [`RDP_OCT_SHIFT_LEN:0]    oct_window;
	logic [`RDP_TRL_WIDTH-1:0]      trl_clamped;
	logic [`RDP_TRL_WIDTH:0]        trl_ext;
	logic [`RDP_TRL_WIDTH:0]        oct_on;
	logic [`RDP_TRL_WIDTH:0]        oct_off;

	// Bit 0 is the enable at the current edge, bit k the enable k edges earlier
	assign rdata_en_shifter = {rdata_en_hist, afi_rdata_en_full_i};

	// Larger tRL values would push the off delay past the history length
	always_comb
	begin
		trl_clamped = (trl_i > TRL_MAX_VAL) ? TRL_MAX_VAL : trl_i;
		trl_ext = {1'b0, trl_clamped};
		oct_on = (trl_ext > ON_OFFSET) ? ((trl_ext - ON_OFFSET) >> 1) : '0;
		oct_off = (trl_ext + OFF_OFFSET) >> 1;
		for (int unsigned k = 0; k <= `RDP_OCT_SHIFT_LEN; k++)
			oct_window[k] = (k >= oct_on) && (k <= oct_off);
	end

	// Termination stays enabled while any enable lies inside the window
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_hist <= rdata_en_shifter[`RDP_OCT_SHIFT_LEN-1:0];
			force_oct_off_o <= ~(|(rdata_en_shifter & oct_window));
		end
	end

endmodule

`default_nettype wire

// File: hw/rdp_read_datapath.sv
// ********************************************************
// Read datapath top level
// Register block, valid predictor, read FIFO and OCT control
// ********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_read_datapath
(
	input  wire logic                            pll_afi_clk,
	input  wire logic                            reset_n_afi_clk,
	// Wishbone classic slave
	input  wire logic                            wb_cyc_i,
	input  wire logic                            wb_stb_i,
	input  wire logic                            wb_we_i,
	input  wire logic [`RDP_WB_ADDR_WIDTH-1:0]   wb_adr_i,
	input  wire logic [`RDP_WB_DATA_WIDTH-1:0]   wb_dat_i,
	output logic      [`RDP_WB_DATA_WIDTH-1:0]   wb_dat_o,
	output logic                                 wb_ack_o,
	// AFI read request side
	input  wire logic                            afi_rdata_en_i,
	input  wire logic                            afi_rdata_en_full_i,
	// Captured DDIO data
	input  wire logic                            ddio_valid_i,
	input  wire rdp_pkg::rdp_read_word_u         ddio_phy_dq_i,
	// AFI read data side
	output logic      [`RDP_AFI_DATA_WIDTH-1:0]  afi_rdata_o,
	output logic      [`RDP_AFI_DATA_WIDTH-1:0]  phy_mux_read_fifo_q_o,
	output logic                                 afi_rdata_valid_o,
	output logic                                 force_oct_off_o
);

	logic [`RDP_LATENCY_WIDTH-1:0]  latency;
	logic [`RDP_TRL_WIDTH-1:0]      trl;
	logic                           fifo_pop;
	logic                           fifo_underflow;
	logic                           fifo_overflow;

	// ********************************************************
	// Configuration and status
	// ********************************************************

	rdp_config_regs i_config_regs
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_dat_o        (wb_dat_o),
		.wb_ack_o        (wb_ack_o),
		.underflow_i     (fifo_underflow),
		.overflow_i      (fifo_overflow),
		.latency_o       (latency),
		.trl_o           (trl)
	);

	// ********************************************************
	// Datapath
	// ********************************************************

	rdp_valid_predictor i_valid_predictor
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_i      (afi_rdata_en_i),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.latency_i           (latency),
		.read_valid_o        (afi_rdata_valid_o),
		.fifo_pop_o          (fifo_pop)
	);

	rdp_read_fifo i_read_fifo
	(
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.push_i                (ddio_valid_i),
		.push_data_i           (ddio_phy_dq_i),
		.pop_i                 (fifo_pop),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.underflow_o           (fifo_underflow),
		.overflow_o            (fifo_overflow)
	);

	rdp_oct_control i_oct_control
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.trl_i               (trl),
		.force_oct_off_o     (force_oct_off_o)
	);

endmodule

`default_nettype wire

// File: test/rdp_read_datapath_sva.sv
// ************************************************************
// Bound checker of the read datapath top level
// Reference models of valid timing, FIFO order, OCT window
// Concurrent assertions on the Wishbone slave and register reads
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rdp_macros.svh"

module rdp_read_datapath_sva
(
	input wire logic                             pll_afi_clk,
	input wire logic                             reset_n_afi_clk,
	input wire logic                             wb_cyc_i,
	input wire logic                             wb_stb_i,
	input wire logic                             wb_we_i,
	input wire logic [`RDP_WB_ADDR_WIDTH-1:0]    wb_adr_i,
	input wire logic [`RDP_WB_DATA_WIDTH-1:0]    wb_dat_i,
	input wire logic [`RDP_WB_DATA_WIDTH-1:0]    wb_dat_o,
	input wire logic                             wb_ack_o,
	input wire logic                             afi_rdata_en_i,
	input wire logic                             afi_rdata_en_full_i,
	input wire logic                             ddio_valid_i,
	input wire logic [`RDP_AFI_DATA_WIDTH-1:0]   ddio_phy_dq_i,
	input wire logic [`RDP_AFI_DATA_WIDTH-1:0]   afi_rdata_o,
	input wire logic [`RDP_AFI_DATA_WIDTH-1:0]   phy_mux_read_fifo_q_o,
	input wire logic                             afi_rdata_valid_o,
	input wire logic                             force_oct_off_o
);

	import rdp_pkg::*;

	// Bit j of en_hist is the read enable seen j+1 edges before the sampling edge
	logic [`RDP_MAX_READ_LATENCY:0]    en_hist;
	logic [`RDP_OCT_SHIFT_LEN:0]       full_hist;
	logic [`RDP_LATENCY_WIDTH-1:0]     lat_q;
	logic [`RDP_TRL_WIDTH-1:0]         trl_q;
	logic [`RDP_AFI_DATA_WIDTH-1:0]    exp_mem [256];
	logic [7:0]                        wr_cnt;
	logic [7:0]                        rd_cnt;
	logic                              exp_empty;
	logic [`RDP_AFI_DATA_WIDTH-1:0]    exp_word;
	logic                              underflow_model;
	logic [`RDP_LATENCY_WIDTH-1:0]     cfg_lat;
	logic [`RDP_TRL_WIDTH-1:0]         cfg_trl;
	logic                              started;
	logic                              wb_take;
	int                                fail_count = 0;

	// Slot t, group g goes to bit t*8+g*4, taken from bit g*16+t*4
	function automatic logic [31:0] slot_major(input logic [31:0] w);
		logic [31:0] r;
		for (int g = 0; g < 2; g++)
			for (int t = 0; t < 4; t++)
				r[t*8+g*4 +: 4] = w[g*16+t*4 +: 4];
		return r;
	endfunction

	// OCT stays on while an enable k edges back lies in [on, off]
	function automatic logic oct_off_expect(input logic [8:0] hist, input logic [3:0] t);
		int tc;
		int on_d;
		int off_d;
		logic seen;
		tc = (t > 10) ? 10 : t;
		on_d = (tc > 4) ? (tc - 4) / 2 : 0;
		off_d = (tc + 6) / 2;
		seen = 1'b0;
		for (int k = on_d; k <= off_d; k++)
			seen |= hist[k];
		return !seen;
	endfunction

	assign wb_take = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign exp_empty = (wr_cnt == rd_cnt);
	assign exp_word = exp_empty ? '0 : exp_mem[rd_cnt];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist <= '0;
			full_hist <= '0;
			lat_q <= '0;
			trl_q <= '0;
			wr_cnt <= '0;
			rd_cnt <= '0;
			underflow_model <= 1'b0;
			cfg_lat <= '0;
			cfg_trl <= '0;
			started <= 1'b0;
		end
		else
		begin
			started <= 1'b1;
			en_hist <= {en_hist[`RDP_MAX_READ_LATENCY-1:0], afi_rdata_en_i};
			full_hist <= {full_hist[`RDP_OCT_SHIFT_LEN-1:0], afi_rdata_en_full_i};
			// Delayed copies of the written fields line up with the registered outputs
			lat_q <= cfg_lat;
			trl_q <= cfg_trl;
			if (ddio_valid_i)
			begin
				exp_mem[wr_cnt] <= ddio_phy_dq_i;
				wr_cnt <= wr_cnt + 1'b1;
			end
			// A valid word leaves the model queue, an empty one is an underflow
			if (afi_rdata_valid_o && !exp_empty)
				rd_cnt <= rd_cnt + 1'b1;
			if (afi_rdata_valid_o && exp_empty)
				underflow_model <= 1'b1;
			else if (wb_take && wb_we_i && wb_adr_i == STATUS && wb_dat_i[0])
				underflow_model <= 1'b0;
			if (wb_take && wb_we_i && wb_adr_i == CONFIG)
			begin
				cfg_lat <= wb_dat_i[3:0];
				cfg_trl <= wb_dat_i[11:8];
			end
		end
	end

	// ************************************************************
	// Assertions
	// ************************************************************

	a_reset_low: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk || $rose(reset_n_afi_clk) |-> !afi_rdata_valid_o && !wb_ack_o)
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: output high around reset", $time);
	end

	a_valid_latency: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == en_hist[lat_q + 5'd1])
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: read valid timing", $time);
	end

	a_slot_order: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o |-> afi_rdata_o == slot_major(phy_mux_read_fifo_q_o))
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: slot-major order", $time);
	end

	a_push_order: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o |-> phy_mux_read_fifo_q_o == exp_word)
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: read word out of order", $time);
	end

	a_oct_window: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		started |-> force_oct_off_o == oct_off_expect(full_hist, trl_q))
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: OCT window", $time);
	end

	a_ack_follows: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		wb_take |=> wb_ack_o)
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: missing ack", $time);
	end

	a_ack_single: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		wb_ack_o |=> !wb_ack_o)
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: ack longer than a cycle", $time);
	end

	a_config_read: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		wb_ack_o && !wb_we_i && wb_adr_i == CONFIG |->
		wb_dat_o == {20'b0, cfg_trl, 4'b0, cfg_lat})
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: CONFIG read", $time);
	end

	a_status_read: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		wb_ack_o && !wb_we_i && wb_adr_i == STATUS |-> wb_dat_o == {31'b0, underflow_model})
	else
	begin
		fail_count++;
		$error("CHECK FAILED at %0t: STATUS read", $time);
	end

endmodule

bind rdp_read_datapath rdp_read_datapath_sva i_sva (.*);

`default_nettype wire

// File: test/tb_read_datapath.sv
// ************************************************************
// Testbench of the read datapath
// Clock, reset, Wishbone and read burst stimulus, watchdog
// Checking is done by the bound assertion module
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

module tb_read_datapath;

	localparam int CLK_PERIOD = 40;
	// Longest burst is 8 pushes, 8 enables with gaps up to 3 and a drain
	localparam int BURST_CYCLES = 8 + 8 * 4 + 30;
	// Two bursts for each of four latencies and three tRL values
	localparam int NUM_BURSTS = 2 * (4 + 3);
	localparam int WB_CYCLES = 8;
	localparam int TEST_CYCLES = NUM_BURSTS * BURST_CYCLES + 16 * WB_CYCLES + 40;

	logic         pll_afi_clk;
	logic         reset_n_afi_clk;
	logic         wb_cyc_i;
	logic         wb_stb_i;
	logic         wb_we_i;
	logic [1:0]   wb_adr_i;
	logic [31:0]  wb_dat_i;
	logic [31:0]  wb_dat_o;
	logic         wb_ack_o;
	logic         afi_rdata_en_i;
	logic         afi_rdata_en_full_i;
	logic         ddio_valid_i;
	logic [31:0]  ddio_phy_dq_i;
	logic [31:0]  afi_rdata_o;
	logic [31:0]  phy_mux_read_fifo_q_o;
	logic         afi_rdata_valid_o;
	logic         force_oct_off_o;

	logic [31:0]  lcg_state = 32'h46e5;
	int           tb_errors = 0;
	int           tests_run = 0;

	rdp_read_datapath i_dut
	(
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.wb_cyc_i              (wb_cyc_i),
		.wb_stb_i              (wb_stb_i),
		.wb_we_i               (wb_we_i),
		.wb_adr_i              (wb_adr_i),
		.wb_dat_i              (wb_dat_i),
		.wb_dat_o              (wb_dat_o),
		.wb_ack_o              (wb_ack_o),
		.afi_rdata_en_i        (afi_rdata_en_i),
		.afi_rdata_en_full_i   (afi_rdata_en_full_i),
		.ddio_valid_i          (ddio_valid_i),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.force_oct_off_o       (force_oct_off_o)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	// Run limit from the summed test lengths
	initial
	begin
		#(TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge pll_afi_clk);
	endtask

	// One classic Wishbone access, held until ack is seen
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat);
		int waited;
		waited = 0;
		@(posedge pll_afi_clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		do
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		while (!wb_ack_o && waited < WB_CYCLES);
		if (!wb_ack_o)
		begin
			$display("Wishbone access at %0t got no acknowledge", $time);
			tb_errors++;
		end
		@(posedge pll_afi_clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i <= 1'b0;
	endtask

	task automatic set_config(input logic [3:0] lat, input logic [3:0] trl_val);
		wb_access(1'b1, 2'd0, {20'b0, trl_val, 4'b0, lat});
	endtask

	// Pushes a random number of words, then requests them with random gaps
	task automatic read_burst();
		int count;
		count = 1 + lcg_next() % 8;
		for (int i = 0; i < count; i++)
		begin
			@(posedge pll_afi_clk);
			ddio_valid_i <= 1'b1;
			ddio_phy_dq_i <= lcg_next();
		end
		@(posedge pll_afi_clk);
		ddio_valid_i <= 1'b0;
		for (int i = 0; i < count; i++)
		begin
			@(posedge pll_afi_clk);
			afi_rdata_en_i <= 1'b1;
			afi_rdata_en_full_i <= 1'b1;
			@(posedge pll_afi_clk);
			afi_rdata_en_i <= 1'b0;
			afi_rdata_en_full_i <= 1'b0;
			idle_cycles(lcg_next() % 3);
		end
		idle_cycles(24);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("Test %s finished, %0d failures so far", name,
			i_dut.i_sva.fail_count + tb_errors);
	endtask

	initial
	begin
		int lat_list [4];
		int trl_list [3];
		lat_list = '{0, 3, 7, 15};
		trl_list = '{4, 8, 12};
		reset_n_afi_clk = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
		ddio_valid_i = 1'b0;
		ddio_phy_dq_i = '0;
		idle_cycles(3);
		reset_n_afi_clk <= 1'b1;
		idle_cycles(4);
		report_test("reset");

		foreach (lat_list[i])
		begin
			set_config(lat_list[i], 4'd8);
			read_burst();
			read_burst();
		end
		report_test("read valid and data order");

		foreach (trl_list[i])
		begin
			set_config(4'd5, trl_list[i]);
			read_burst();
			read_burst();
		end
		report_test("OCT window");

		set_config(4'd9, 4'd6);
		wb_access(1'b0, 2'd0, '0);
		wb_access(1'b0, 2'd1, '0);
		wb_access(1'b0, 2'd2, '0);
		report_test("Wishbone");

		// A request with nothing pushed pops an empty FIFO
		set_config(4'd2, 4'd4);
		@(posedge pll_afi_clk);
		afi_rdata_en_i <= 1'b1;
		afi_rdata_en_full_i <= 1'b1;
		@(posedge pll_afi_clk);
		afi_rdata_en_i <= 1'b0;
		afi_rdata_en_full_i <= 1'b0;
		idle_cycles(10);
		wb_access(1'b0, 2'd1, '0);
		wb_access(1'b0, 2'd1, '0);
		wb_access(1'b1, 2'd1, 32'h1);
		wb_access(1'b0, 2'd1, '0);
		report_test("underflow");

		idle_cycles(4);
		$display("Tests run: %0d, failures: %0d", tests_run, i_dut.i_sva.fail_count + tb_errors);
		if (i_dut.i_sva.fail_count + tb_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/rdp_pkg.sv
hw/rdp_config_regs.sv
hw/rdp_valid_predictor.sv
hw/rdp_read_fifo.sv
hw/rdp_oct_control.sv
hw/rdp_read_datapath.sv
test/rdp_read_datapath_sva.sv
test/tb_read_datapath.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_read_datapath
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
